//--- rtl/uart_pkg.sv
// Serial line definitions: character width, default bit divider, receiver and transmitter states
`default_nettype none

package uart_pkg;

    //////////////////////////////////////////////////////////////////////
    // Character format
    //////////////////////////////////////////////////////////////////////

    // 8N1 payload width
    localparam int unsigned UART_DAT_W = 8;

    // 27 MHz crystal, 115200 baud
    localparam int unsigned UART_CLK_DIV_DEF = 234;

    //////////////////////////////////////////////////////////////////////
    // FSM states
    //////////////////////////////////////////////////////////////////////

    // Receiver
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    // Transmitter
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage: uart_pkg

`default_nettype wire

//--- rtl/cmd_pkg.sv
// Command protocol definitions: opcodes, reply bytes and executor states
`default_nettype none

package cmd_pkg;

    //////////////////////////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////////////////////////

    // ASCII letters, so a terminal can drive the board by hand
    typedef enum logic [7:0] {
        // 'W' plus data byte
        OP_GPIO_WR = 8'h57,
        // 'R', no argument
        OP_GPIO_RD = 8'h52,
        // 'E' plus data byte
        OP_ECHO    = 8'h45
    } cmd_op_t;

    //////////////////////////////////////////////////////////////////////
    // Reply bytes
    //////////////////////////////////////////////////////////////////////

    // 'K' after a GPIO write
    localparam logic [7:0] CMD_REPLY_ACK = 8'h4B;

    // '?' for an unknown opcode
    localparam logic [7:0] CMD_REPLY_ERR = 8'h3F;

    //////////////////////////////////////////////////////////////////////
    // Executor FSM
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        CMD_IDLE,
        CMD_ARG,
        CMD_REPLY
    } cmd_state_t;

endpackage: cmd_pkg

`default_nettype wire

//--- rtl/uart_rx.sv
// UART 8N1 receiver module with mid-bit sampling and per-byte valid strobe
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    // Clock cycles per bit
    parameter int unsigned CLK_DIV = uart_pkg::UART_CLK_DIV_DEF
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // Serial input, asynchronous to clk
    input  logic                            rxd,
    // Received byte and its strobe
    output logic [uart_pkg::UART_DAT_W-1:0] rx_data,
    output logic                            rx_valid
);

    import uart_pkg::*;

    localparam int unsigned CNT_W = $clog2(CLK_DIV);

    // Input synchronizer, last stage kept for edge detection
    logic [2:0] rxd_sync;
    logic       rxd_s;
    logic       rxd_fall;

    rx_state_t       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [2:0]       bit_q;
    logic [UART_DAT_W-1:0] shr_q;

    assign rxd_s    = rxd_sync[1];
    assign rxd_fall = rxd_sync[2] & ~rxd_sync[1];

    // Idle line is high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_sync <= '1;
        end else begin
            rxd_sync <= {rxd_sync[1:0], rxd};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Receiver FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= RX_IDLE;
            cnt_q    <= '0;
            bit_q    <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
            case (state_q)
                RX_IDLE: begin
                    // Half a bit to reach the middle of the start bit
                    if (rxd_fall) begin
                        state_q <= RX_START;
                        cnt_q   <= CNT_W'(CLK_DIV/2 - 1);
                    end
                end
                RX_START: begin
                    if (cnt_q == '0) begin
                        // Glitch shorter than half a bit
                        state_q <= rxd_s ? RX_IDLE : RX_DATA;
                        cnt_q   <= CNT_W'(CLK_DIV - 1);
                        bit_q   <= '0;
                    end
                end
                RX_DATA: begin
                    if (cnt_q == '0) begin
                        cnt_q <= CNT_W'(CLK_DIV - 1);
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    // Framing error drops the byte silently
                    if (cnt_q == '0) begin
                        rx_valid <= rxd_s;
                        state_q  <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && cnt_q == '0) begin
            shr_q <= {rxd_s, shr_q[UART_DAT_W-1:1]};
        end
    end

    assign rx_data = shr_q;

endmodule: uart_rx

`default_nettype wire

//--- rtl/uart_fifo.sv
// Show-ahead synchronous FIFO module for received UART bytes
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
    // Depth, power of two
    parameter int unsigned FIFO_SIZ = 16
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // Write side, from the receiver
    input  logic [uart_pkg::UART_DAT_W-1:0] wr_data,
    input  logic                            wr_en,
    // Read side, head entry always presented
    output logic [uart_pkg::UART_DAT_W-1:0] rd_data,
    input  logic                            rd_en,
    output logic                            empty
);

    import uart_pkg::*;

    localparam int unsigned ADR_W = $clog2(FIFO_SIZ);

    logic [UART_DAT_W-1:0] mem [FIFO_SIZ];

    // Extra MSB tells full from empty
    logic [ADR_W:0] wr_ptr;
    logic [ADR_W:0] rd_ptr;
    logic           full;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADR_W] != rd_ptr[ADR_W]) &&
                   (wr_ptr[ADR_W-1:0] == rd_ptr[ADR_W-1:0]);

    //////////////////////////////////////////////////////////////////////
    // Pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            // Overflow bytes are lost
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en && !full) begin
            mem[wr_ptr[ADR_W-1:0]] <= wr_data;
        end
    end

    // No read latency
    assign rd_data = mem[rd_ptr[ADR_W-1:0]];

endmodule: uart_fifo

`default_nettype wire

//--- rtl/cmd_exec.sv
// Command executor module: opcode decode, GPIO access and reply generation
`timescale 1ns/1ps
`default_nettype none

module cmd_exec #(
    // GPIO width, 1 to 8
    parameter int unsigned GPIO_DAT = 6
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // FIFO head
    input  logic [uart_pkg::UART_DAT_W-1:0] fifo_data,
    input  logic                            fifo_empty,
    output logic                            fifo_pop,
    // Reply to the transmitter
    output logic [uart_pkg::UART_DAT_W-1:0] tx_data,
    output logic                            tx_start,
    input  logic                            tx_busy,
    // GPIO
    output logic [GPIO_DAT-1:0]             gpio_o,
    input  logic [GPIO_DAT-1:0]             gpio_i
);

    import uart_pkg::*;
    import cmd_pkg::*;

    cmd_state_t            state_q;
    // Opcode waiting for its argument
    cmd_op_t               op_q;
    logic [UART_DAT_W-1:0] reply_q;
    logic [UART_DAT_W-1:0] gpio_ext;
    cmd_op_t               op_in;

    // Zero extension, valid for GPIO_DAT up to the full byte
    always_comb begin
        gpio_ext = '0;
        gpio_ext[GPIO_DAT-1:0] = gpio_i;
    end

    // Head byte seen as an opcode
    assign op_in = cmd_op_t'(fifo_data);

    //////////////////////////////////////////////////////////////////////
    // Handshake strobes
    //////////////////////////////////////////////////////////////////////

    // Opcode and argument are both taken straight from the head
    assign fifo_pop = (state_q inside {CMD_IDLE, CMD_ARG}) && !fifo_empty;
    // Wait for the previous reply to leave
    assign tx_start = (state_q == CMD_REPLY) && !tx_busy;
    assign tx_data  = reply_q;

    //////////////////////////////////////////////////////////////////////
    // Executor FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= CMD_IDLE;
            op_q    <= OP_ECHO;
            gpio_o  <= '0;
        end else begin
            case (state_q)
                CMD_IDLE: begin
                    if (!fifo_empty) begin
                        op_q <= op_in;
                        case (op_in)
                            OP_GPIO_WR,
                            OP_ECHO:    state_q <= CMD_ARG;
                            default:    state_q <= CMD_REPLY;
                        endcase
                    end
                end
                CMD_ARG: begin
                    if (!fifo_empty) begin
                        if (op_q == OP_GPIO_WR) begin
                            gpio_o <= fifo_data[GPIO_DAT-1:0];
                        end
                        state_q <= CMD_REPLY;
                    end
                end
                CMD_REPLY: begin
                    // One reply byte per command
                    if (!tx_busy) begin
                        state_q <= CMD_IDLE;
                    end
                end
                default: state_q <= CMD_IDLE;
            endcase
        end
    end

    // Reply byte, prepared before REPLY is entered
    always_ff @(posedge clk) begin
        if (state_q == CMD_IDLE && !fifo_empty) begin
            // GPIO inputs sampled at decode
            reply_q <= (op_in == OP_GPIO_RD) ? gpio_ext : CMD_REPLY_ERR;
        end else if (state_q == CMD_ARG && !fifo_empty) begin
            reply_q <= (op_q == OP_GPIO_WR) ? CMD_REPLY_ACK : fifo_data;
        end
    end

endmodule: cmd_exec

`default_nettype wire

//--- rtl/uart_tx.sv
// UART 8N1 transmitter module with start strobe and busy level
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    // Clock cycles per bit
    parameter int unsigned CLK_DIV = uart_pkg::UART_CLK_DIV_DEF
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // Byte to send, strobe only while not busy
    input  logic [uart_pkg::UART_DAT_W-1:0] tx_data,
    input  logic                            tx_start,
    output logic                            tx_busy,
    // Serial output
    output logic                            txd
);

    import uart_pkg::*;

    localparam int unsigned CNT_W = $clog2(CLK_DIV);

    tx_state_t             state_q;
    logic [CNT_W-1:0]      cnt_q;
    logic [2:0]            bit_q;
    logic [UART_DAT_W-1:0] shr_q;

    // High from the cycle after the strobe to the end of stop
    assign tx_busy = (state_q != TX_IDLE);

    //////////////////////////////////////////////////////////////////////
    // Transmitter FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= TX_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            txd     <= 1'b1;
        end else begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
            case (state_q)
                TX_IDLE: begin
                    if (tx_start) begin
                        // Start bit goes out right away
                        state_q <= TX_START;
                        cnt_q   <= CNT_W'(CLK_DIV - 1);
                        txd     <= 1'b0;
                    end
                end
                TX_START: begin
                    if (cnt_q == '0) begin
                        state_q <= TX_DATA;
                        cnt_q   <= CNT_W'(CLK_DIV - 1);
                        bit_q   <= '0;
                        txd     <= shr_q[0];
                    end
                end
                TX_DATA: begin
                    if (cnt_q == '0) begin
                        cnt_q <= CNT_W'(CLK_DIV - 1);
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= TX_STOP;
                            txd     <= 1'b1;
                        end else begin
                            txd <= shr_q[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (cnt_q == '0) begin
                        state_q <= TX_IDLE;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // Payload latched on the strobe, LSB leaves first
    always_ff @(posedge clk) begin
        if (state_q == TX_IDLE && tx_start) begin
            shr_q <= tx_data;
        end else if (state_q == TX_DATA && cnt_q == '0) begin
            shr_q <= shr_q >> 1;
        end
    end

endmodule: uart_tx

`default_nettype wire

//--- rtl/degu_soc_top.sv
// Top level module: UART receiver, byte FIFO, command executor and UART transmitter
`timescale 1ns/1ps
`default_nettype none

module degu_soc_top #(
    // GPIO width, 1 to 8
    parameter int unsigned GPIO_DAT = 6,
    // Receive FIFO depth, power of two
    parameter int unsigned FIFO_SIZ = 16,
    // Clock cycles per serial bit, at least 4
    parameter int unsigned CLK_DIV  = uart_pkg::UART_CLK_DIV_DEF
) (
    // Board crystal
    input  logic                clk,
    input  logic                rst_n,
    // UART
    input  logic                uart_rxd,
    output logic                uart_txd,
    // GPIO
    output logic [GPIO_DAT-1:0] gpio_o,
    input  logic [GPIO_DAT-1:0] gpio_i
);

    import uart_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Local signals
    //////////////////////////////////////////////////////////////////////

    // Receiver to FIFO
    logic [UART_DAT_W-1:0] rx_data;
    logic                  rx_valid;

    // FIFO to executor
    logic [UART_DAT_W-1:0] fifo_data;
    logic                  fifo_empty;
    logic                  fifo_pop;

    // Executor to transmitter
    logic [UART_DAT_W-1:0] tx_data;
    logic                  tx_start;
    logic                  tx_busy;

    //////////////////////////////////////////////////////////////////////
    // Receive path
    //////////////////////////////////////////////////////////////////////

    uart_rx #(
        .CLK_DIV  (CLK_DIV)
    ) i_uart_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rxd      (uart_rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    // Absorbs bytes while a reply is on the line
    uart_fifo #(
        .FIFO_SIZ (FIFO_SIZ)
    ) i_uart_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_data  (rx_data),
        .wr_en    (rx_valid),
        .rd_data  (fifo_data),
        .rd_en    (fifo_pop),
        .empty    (fifo_empty)
    );

    //////////////////////////////////////////////////////////////////////
    // Command engine and transmit path
    //////////////////////////////////////////////////////////////////////

    cmd_exec #(
        .GPIO_DAT   (GPIO_DAT)
    ) i_cmd_exec (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_data  (fifo_data),
        .fifo_empty (fifo_empty),
        .fifo_pop   (fifo_pop),
        .tx_data    (tx_data),
        .tx_start   (tx_start),
        .tx_busy    (tx_busy),
        .gpio_o     (gpio_o),
        .gpio_i     (gpio_i)
    );

    uart_tx #(
        .CLK_DIV  (CLK_DIV)
    ) i_uart_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .txd      (uart_txd)
    );

endmodule: degu_soc_top

`default_nettype wire

//--- tests/tb_clk_gen.sv
// Testbench clock and synchronous reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    // Clock period in ns
    parameter int unsigned PERIOD_NS = 20,
    // Cycles with reset held low
    parameter int unsigned RST_CYC   = 2
) (
    output logic clk,
    output logic rst_n
);

    // Free-running clock, low at time zero
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released on a rising edge, as the DUT samples it
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule: tb_clk_gen

`default_nettype wire

//--- tests/tb_degu_soc.sv
// Testbench top with trace reader, serial driver and monitor, value checks and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_degu_soc;

    localparam int unsigned CLK_DIV    = 16;
    localparam int unsigned FIFO_SIZ   = 16;
    localparam int unsigned GPIO_DAT   = 6;
    // Seven byte columns per trace line
    localparam int unsigned TRC_COL    = 7;
    localparam int unsigned TRC_MAX    = 64;
    localparam int unsigned COL_MODE   = 0;
    localparam int unsigned COL_GPIO   = 1;
    localparam int unsigned COL_NB     = 2;
    localparam int unsigned COL_B0     = 3;
    localparam int unsigned COL_B1     = 4;
    localparam int unsigned COL_REPLY  = 5;
    localparam int unsigned COL_GPO    = 6;
    // Line modes
    localparam logic [7:0] MODE_BURST  = 8'h01;
    localparam logic [7:0] MODE_END    = 8'hff;
    // Slack on top of the computed run length
    localparam int unsigned TMO_MARGIN = 2000;

    logic                clk;
    logic                rst_n;
    logic                uart_rxd;
    logic                uart_txd;
    logic [GPIO_DAT-1:0] gpio_o;
    logic [GPIO_DAT-1:0] gpio_i;

    logic [7:0]  trace_mem [TRC_COL*TRC_MAX];
    int unsigned n_lines;
    int unsigned timeout_cyc;
    int unsigned cycle_cnt;
    // Bytes decoded from uart_txd in arrival order
    logic [7:0]  reply_fifo [$];

    //////////////////////////////////////////////////////////////////////
    // Clock, reset and DUT
    //////////////////////////////////////////////////////////////////////

    tb_clk_gen #(
        .PERIOD_NS (20),
        .RST_CYC   (2)
    ) i_tb_clk_gen (
        .clk       (clk),
        .rst_n     (rst_n)
    );

    degu_soc_top #(
        .GPIO_DAT (GPIO_DAT),
        .FIFO_SIZ (FIFO_SIZ),
        .CLK_DIV  (CLK_DIV)
    ) i_degu_soc_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd),
        .gpio_o   (gpio_o),
        .gpio_i   (gpio_i)
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s got 0x%02h expected 0x%02h",
                                name, got, exp));
        end
    endtask

    function automatic logic [7:0] trace_field(input int unsigned idx,
                                               input int unsigned col);
        return trace_mem[idx*TRC_COL + col];
    endfunction

    // 8N1 frame sent start bit first with every bit held CLK_DIV cycles
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rxd <= frame[i];
            repeat (CLK_DIV - 1) @(posedge clk);
        end
    endtask

    task automatic send_command(input int unsigned idx);
        send_byte(trace_field(idx, COL_B0));
        if (trace_field(idx, COL_NB) == 8'h02) begin
            send_byte(trace_field(idx, COL_B1));
        end
    endtask

    task automatic set_gpio_in(input logic [7:0] value);
        @(posedge clk);
        gpio_i <= value[GPIO_DAT-1:0];
    endtask

    // Oldest decoded reply against the trace
    task automatic check_reply(input int unsigned idx);
        logic [7:0] got;
        while (reply_fifo.size() == 0) @(posedge clk);
        got = reply_fifo.pop_front();
        check_value($sformatf("uart_txd reply (trace line %0d)", idx), got,
                    trace_field(idx, COL_REPLY));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Watchdog and serial monitor
    //////////////////////////////////////////////////////////////////////

    initial begin : watchdog
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (timeout_cyc != 0 && cycle_cnt > timeout_cyc) begin
                abort_run($sformatf("Timeout: test still running after %0d cycles",
                                    cycle_cnt));
            end
        end
    end

    // Samples each bit near its middle on falling clock edges
    initial begin : serial_monitor
        logic [7:0] rx_byte;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge uart_txd);
            repeat (CLK_DIV / 2) @(negedge clk);
            if (uart_txd !== 1'b0) begin
                abort_run("Start bit on uart_txd was shorter than half a bit");
            end
            for (int i = 0; i < 8; i++) begin
                repeat (CLK_DIV) @(negedge clk);
                rx_byte[i] = uart_txd;
            end
            repeat (CLK_DIV) @(negedge clk);
            if (uart_txd !== 1'b1) begin
                abort_run("Stop bit on uart_txd was low");
            end
            reply_fifo.push_back(rx_byte);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : main_seq
        int unsigned idx;
        int unsigned first;
        uart_rxd    = 1'b1;
        gpio_i      = '0;
        timeout_cyc = 0;
        n_lines     = 0;
        $readmemh("tests/cmd_trace.txt", trace_mem);
        while (n_lines < TRC_MAX && trace_mem[n_lines*TRC_COL] !== MODE_END) begin
            n_lines++;
        end
        if (n_lines == 0 || n_lines == TRC_MAX) begin
            abort_run("Trace file tests/cmd_trace.txt is missing or has no end line");
        end
        // Two sent bytes and one reply per line with a factor of two
        timeout_cyc = n_lines * 3 * 10 * CLK_DIV * 2 + TMO_MARGIN;

        // Reset state before any stimulus
        while (rst_n !== 1'b1) @(posedge clk);
        @(negedge clk);
        check_value("uart_txd", 8'(uart_txd), 8'h01);
        check_value("gpio_o", 8'(gpio_o), 8'h00);

        idx = 0;
        while (idx < n_lines) begin
            if (trace_field(idx, COL_MODE) == MODE_BURST) begin
                // Burst bytes leave without a gap while replies queue up behind
                first = idx;
                set_gpio_in(trace_field(idx, COL_GPIO));
                while (idx < n_lines && trace_field(idx, COL_MODE) == MODE_BURST) begin
                    send_command(idx);
                    idx++;
                end
                for (int unsigned k = first; k < idx; k++) begin
                    check_reply(k);
                end
                @(negedge clk);
                check_value("gpio_o", 8'(gpio_o), trace_field(idx - 1, COL_GPO));
            end else begin
                set_gpio_in(trace_field(idx, COL_GPIO));
                send_command(idx);
                check_reply(idx);
                @(negedge clk);
                check_value("gpio_o", 8'(gpio_o), trace_field(idx, COL_GPO));
                idx++;
            end
        end

        // A spurious reply would be decoded within two characters
        repeat (2 * 10 * CLK_DIV) @(posedge clk);
        check_value("extra reply count", 8'(reply_fifo.size()), 8'h00);
        $display("Simulation PASSED");
        $finish;
    end

endmodule: tb_degu_soc

`default_nettype wire

//--- tests/cmd_trace.txt
// Columns: mode gpio_i nbytes byte0 byte1 exp_reply exp_gpio_o (hex)
// Mode 00 single command, 01 burst member, ff end of trace
// GPIO writes
00 00 02 57 2a 4b 2a
00 00 02 57 ff 4b 3f
00 00 02 57 c5 4b 05
// GPIO reads, reply is gpio_i zero-extended
00 15 01 52 00 15 05
00 3f 01 52 00 3f 05
00 00 01 52 00 00 05
// Echo
00 00 02 45 a5 a5 05
00 00 02 45 00 00 05
00 00 02 45 57 57 05
// Unknown opcodes leave gpio_o alone
00 00 01 00 00 3f 05
00 00 01 77 00 3f 05
00 00 01 4b 00 3f 05
00 00 02 57 12 4b 12
// Burst of eleven bytes, no gap between commands
01 2c 02 57 31 4b 31
01 2c 01 52 00 2c 31
01 2c 02 45 5a 5a 31
01 2c 01 3f 00 3f 31
01 2c 02 57 0c 4b 0c
01 2c 01 52 00 2c 0c
01 2c 02 45 c3 c3 0c
// Single read after the burst
00 0a 01 52 00 0a 0c
// End of trace
ff 00 00 00 00 00 00

//--- filelist.f
rtl/uart_pkg.sv
rtl/cmd_pkg.sv
rtl/uart_rx.sv
rtl/uart_fifo.sv
rtl/cmd_exec.sv
rtl/uart_tx.sv
rtl/degu_soc_top.sv
tests/tb_clk_gen.sv
tests/tb_degu_soc.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_degu_soc \
    -f filelist.f \
    -o tb_degu_soc

# A failing run exits nonzero, so keep going to read the log
./obj_dir/tb_degu_soc > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Simulation PASSED" "$LOG"; then
    echo "run_sim: pass"
else
    echo "run_sim: fail"
    exit 1
fi
